/* Makefile */
# Verilator build and run for the valid-ready FIFO testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fifo_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -Wno-fatal
SEED_ARGS ?= +verilator+seed+1

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove the build directory $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SEED_ARGS"

# The simulator exits non-zero on $$fatal, so make fails with it
test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

/* design/advanced_fifo_controller.sv */
// FIFO pointer controller
// Tracks write and read pointers and occupancy, issues RAM writes and read address
`timescale 1ns/10ps
`include "fifo_defines.svh"

module advanced_fifo_controller (
  input  logic                  clock,
  input  logic                  rst_n,
  // Synchronous flush, wins over write and read
  input  logic                  flush,
  // Accepted write transfer
  input  logic                  write_enable,
  input  fifo_pkg::fifo_data_t  write_data,
  // Accepted read transfer
  input  logic                  read_enable,
  // Occupancy and free space
  output fifo_pkg::fifo_count_t count,
  output fifo_pkg::fifo_count_t space,
  // RAM interface
  output fifo_pkg::ram_write_t  ram_write,
  output fifo_pkg::fifo_addr_t  read_address
);

  import fifo_pkg::*;

  // Depth as a count value
  localparam fifo_count_t DEPTH_COUNT = fifo_count_t'(`FIFO_DEPTH);
  // Last valid index before wrap
  localparam fifo_addr_t  LAST_ADDR   = fifo_addr_t'(`FIFO_DEPTH - 1);

  // Pointer registers
  fifo_addr_t  write_pointer;
  fifo_addr_t  read_pointer;
  // Next pointer values
  fifo_addr_t  write_pointer_next;
  fifo_addr_t  read_pointer_next;

  // Occupancy register and its next value
  fifo_count_t count_reg;
  fifo_count_t count_next;

  // Transfers that really happen this cycle
  logic        write_accept;
  logic        read_accept;

  // Increment with wrap at the depth
  function automatic fifo_addr_t next_address(input fifo_addr_t address);
    fifo_addr_t result;
    if (address == LAST_ADDR) begin
      result = '0;
    end else begin
      result = address + 1'b1;
    end
    return result;
  endfunction

  // A flush drops any transfer in the same cycle
  assign write_accept = write_enable & ~flush;
  assign read_accept  = read_enable & ~flush;

  // Write pointer advance
  always_comb begin
    write_pointer_next = write_pointer;
    if (write_accept) begin
      write_pointer_next = next_address(write_pointer);
    end
  end

  // Read pointer advance
  always_comb begin
    read_pointer_next = read_pointer;
    if (read_accept) begin
      read_pointer_next = next_address(read_pointer);
    end
  end

  // Occupancy follows write minus read
  always_comb begin
    count_next = count_reg;
    case ({write_accept, read_accept})
      // Push only
      2'b10: count_next = count_reg + 1'b1;
      // Pop only
      2'b01: count_next = count_reg - 1'b1;
      // Idle or push and pop together
      default: count_next = count_reg;
    endcase
  end

  // Pointer and count state
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      write_pointer <= '0;
      read_pointer  <= '0;
      count_reg     <= '0;
    end else if (flush) begin
      // Back to empty, both pointers at the start
      write_pointer <= '0;
      read_pointer  <= '0;
      count_reg     <= '0;
    end else begin
      write_pointer <= write_pointer_next;
      read_pointer  <= read_pointer_next;
      count_reg     <= count_next;
    end
  end

  // RAM write at the current write pointer
  always_comb begin
    ram_write.enable  = write_accept;
    ram_write.address = write_pointer;
    ram_write.data    = write_data;
  end

  // Head of the queue
  assign read_address = read_pointer;

  // Status counts
  assign count = count_reg;
  // Free slots left
  assign space = DEPTH_COUNT - count_reg;

endmodule

/* design/fifo_pkg.sv */
// FIFO types package
// Payload, address and count vectors plus the flag and RAM-write structs
`include "fifo_defines.svh"

package fifo_pkg;

  // One payload word
  typedef logic [`FIFO_WIDTH-1:0] fifo_data_t;
  // RAM address and pointer index
  typedef logic [`FIFO_ADDR_W-1:0] fifo_addr_t;
  // Occupancy or free space, 0 up to the depth inclusive
  typedef logic [`FIFO_ADDR_W:0] fifo_count_t;

  // Status flags, MSB first
  typedef struct packed {
    logic empty;
    logic almost_empty;
    logic half_empty;
    logic not_empty;
    logic not_full;
    logic half_full;
    logic almost_full;
    logic full;
  } fifo_flags_t;

  // Write port bundle from controller to RAM
  typedef struct packed {
    logic       enable;
    fifo_addr_t address;
    fifo_data_t data;
  } ram_write_t;

endpackage

/* design/fifo_status_flags.sv */
// FIFO status flag generation
// Derives the eight occupancy flags and both threshold statuses from the count
`timescale 1ns/10ps
`include "fifo_defines.svh"

module fifo_status_flags (
  // Current occupancy
  input  fifo_pkg::fifo_count_t count,
  // Programmable thresholds
  input  fifo_pkg::fifo_count_t lower_threshold_level,
  input  fifo_pkg::fifo_count_t upper_threshold_level,
  // Outputs
  output fifo_pkg::fifo_flags_t flags,
  output logic                  lower_threshold_status,
  output logic                  upper_threshold_status
);

  import fifo_pkg::*;

  // Comparison points, all sized to the count
  localparam fifo_count_t FULL_COUNT         = fifo_count_t'(`FIFO_DEPTH);
  localparam fifo_count_t HALF_COUNT         = fifo_count_t'(`FIFO_DEPTH / 2);
  localparam fifo_count_t ALMOST_FULL_COUNT  = fifo_count_t'(`FIFO_DEPTH - 1);
  localparam fifo_count_t ALMOST_EMPTY_COUNT = fifo_count_t'(1);
  localparam fifo_count_t EMPTY_COUNT        = fifo_count_t'(0);

  always_comb begin
    // Empty side
    flags.empty        = (count == EMPTY_COUNT);
    flags.not_empty    = (count != EMPTY_COUNT);
    // At most one entry left
    flags.almost_empty = (count <= ALMOST_EMPTY_COUNT);
    // Half point counts for both halves
    flags.half_empty   = (count <= HALF_COUNT);
    flags.half_full    = (count >= HALF_COUNT);
    // At most one free slot
    flags.almost_full  = (count >= ALMOST_FULL_COUNT);
    // Full side
    flags.full         = (count == FULL_COUNT);
    flags.not_full     = (count != FULL_COUNT);
  end

  // Threshold statuses
  // Inclusive comparisons on both sides
  always_comb begin
    lower_threshold_status = (count <= lower_threshold_level);
    upper_threshold_status = (count >= upper_threshold_level);
  end

endmodule

/* design/simple_dual_port_ram.sv */
// Simple dual-port RAM
// One synchronous write port, one combinational read port
`timescale 1ns/10ps
`include "fifo_defines.svh"

module simple_dual_port_ram (
  input  logic                clock,
  // Write port bundle
  input  fifo_pkg::ram_write_t ram_write,
  // Read port
  input  fifo_pkg::fifo_addr_t read_address,
  output fifo_pkg::fifo_data_t read_data
);

  import fifo_pkg::*;

  // Storage array, one word per entry
  fifo_data_t memory [`FIFO_DEPTH];

  // Write on the rising edge when enabled
  always_ff @(posedge clock) begin
    if (ram_write.enable) begin
      memory[ram_write.address] <= ram_write.data;
    end
  end

  // Zero-latency read
  // Data follows the address within the same cycle
  assign read_data = memory[read_address];

endmodule

/* design/valid_ready_advanced_fifo.sv */
// Valid-ready FIFO top level
// Handshake on both sides around controller, flag block and zero-latency RAM
`timescale 1ns/10ps

module valid_ready_advanced_fifo (
  input  logic                  clock,
  input  logic                  rst_n,
  input  logic                  flush,
  // Write side
  input  fifo_pkg::fifo_data_t  write_data,
  input  logic                  write_valid,
  output logic                  write_ready,
  // Read side
  output fifo_pkg::fifo_data_t  read_data,
  output logic                  read_valid,
  input  logic                  read_ready,
  // Status
  output fifo_pkg::fifo_flags_t flags,
  output fifo_pkg::fifo_count_t level,
  output fifo_pkg::fifo_count_t space,
  // Thresholds
  input  fifo_pkg::fifo_count_t lower_threshold_level,
  output logic                  lower_threshold_status,
  input  fifo_pkg::fifo_count_t upper_threshold_level,
  output logic                  upper_threshold_status
);

  import fifo_pkg::*;

  // Accepted transfer strobes
  logic       write_enable;
  logic       read_enable;

  // Controller to RAM
  ram_write_t ram_write;
  fifo_addr_t read_address;

  // Ready when there is room, valid when there is data
  assign write_ready  = flags.not_full;
  assign read_valid   = flags.not_empty;
  assign write_enable = write_valid & write_ready;
  assign read_enable  = read_valid & read_ready;

  // Pointers and occupancy
  advanced_fifo_controller controller (
    .clock        ( clock        ),
    .rst_n        ( rst_n        ),
    .flush        ( flush        ),
    .write_enable ( write_enable ),
    .write_data   ( write_data   ),
    .read_enable  ( read_enable  ),
    .count        ( level        ),
    .space        ( space        ),
    .ram_write    ( ram_write    ),
    .read_address ( read_address )
  );

  // Flags follow the count combinationally
  fifo_status_flags status (
    .count                  ( level                  ),
    .lower_threshold_level  ( lower_threshold_level  ),
    .upper_threshold_level  ( upper_threshold_level  ),
    .flags                  ( flags                  ),
    .lower_threshold_status ( lower_threshold_status ),
    .upper_threshold_status ( upper_threshold_status )
  );

  // Storage, head word read out directly
  simple_dual_port_ram memory (
    .clock        ( clock        ),
    .ram_write    ( ram_write    ),
    .read_address ( read_address ),
    .read_data    ( read_data    )
  );

endmodule

/* include/fifo_defines.svh */
// FIFO geometry macros
// Shared by the package and every block that sizes storage or counts
`ifndef FIFO_DEFINES_SVH
`define FIFO_DEFINES_SVH

// Payload width in bits
`define FIFO_WIDTH 8

// Number of entries
// Must stay a power of two so the pointers wrap cleanly
`define FIFO_DEPTH 8

// Pointer and RAM address width
// log2 of the depth
`define FIFO_ADDR_W $clog2(`FIFO_DEPTH)

`endif

/* test/fifo_tb_checks.svh */
// FIFO testbench checks and queue model
// Compare tasks for each result kind and the reference queue for random traffic
`ifndef FIFO_TB_CHECKS_SVH
`define FIFO_TB_CHECKS_SVH

// Reference queue with the head at index 0
fifo_data_t model_q[$];

// Ends the run after an error line was printed
task automatic abort_run();
  $display("TEST FAILED");
  $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_data(input string test_name, input fifo_data_t expected,
                          input fifo_data_t actual);
  if (actual !== expected) begin
    $display("FAILED %s: read_data expected %h, actual %h", test_name, expected, actual);
    abort_run();
  end
endtask

task automatic check_count(input string test_name, input string what,
                           input fifo_count_t expected, input fifo_count_t actual);
  if (actual !== expected) begin
    $display("FAILED %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    abort_run();
  end
endtask

task automatic check_flags(input string test_name, input fifo_flags_t expected,
                           input fifo_flags_t actual);
  if (actual !== expected) begin
    $display("FAILED %s: flags expected %b, actual %b", test_name, expected, actual);
    abort_run();
  end
endtask

// Single-bit handshake and threshold outputs
task automatic check_status(input string test_name, input string what,
                            input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("FAILED %s: %s expected %b, actual %b", test_name, what, expected, actual);
    abort_run();
  end
endtask

// Flag pattern looked up per occupancy from the worked-out table
function automatic fifo_flags_t expected_flags(input int c);
  fifo_flags_t f;
  case (c)
    0: f = FLAGS_0;
    1: f = FLAGS_1;
    2: f = FLAGS_2;
    3: f = FLAGS_3;
    4: f = FLAGS_4;
    5: f = FLAGS_5;
    6: f = FLAGS_6;
    7: f = FLAGS_7;
    8: f = FLAGS_8;
    default: f = 'x;
  endcase
  return f;
endfunction

// One clock edge of the model
// Flush wins over both transfers
task automatic model_step(input logic do_flush, input logic do_push,
                          input fifo_data_t data, input logic do_pop);
  if (do_flush) begin
    model_q.delete();
  end else begin
    if (do_pop) begin
      void'(model_q.pop_front());
    end
    if (do_push) begin
      model_q.push_back(data);
    end
  end
endtask

`endif

/* test/fifo_tb.sv */
// Valid-ready FIFO testbench
// Directed table then seeded random traffic against a queue model
`timescale 1ns/10ps
`include "fifo_defines.svh"

module fifo_tb;

  import fifo_pkg::*;

  localparam int unsigned RANDOM_SEED   = 32'hebce_b25a;
  localparam int          RANDOM_CYCLES = 400;

  // Expected flags per occupancy
  // MSB is empty
  localparam fifo_flags_t FLAGS_0 = 8'he8;
  localparam fifo_flags_t FLAGS_1 = 8'h78;
  localparam fifo_flags_t FLAGS_2 = 8'h38;
  localparam fifo_flags_t FLAGS_3 = 8'h38;
  localparam fifo_flags_t FLAGS_4 = 8'h3c;
  localparam fifo_flags_t FLAGS_5 = 8'h1c;
  localparam fifo_flags_t FLAGS_6 = 8'h1c;
  localparam fifo_flags_t FLAGS_7 = 8'h1e;
  localparam fifo_flags_t FLAGS_8 = 8'h17;

  // Stimulus for one cycle and the state expected after its edge
  typedef struct packed {
    logic        flush;
    logic        write_valid;
    fifo_data_t  write_data;
    logic        read_ready;
    fifo_count_t lower_level;
    fifo_count_t upper_level;
    fifo_count_t exp_count;
    fifo_flags_t exp_flags;
    fifo_data_t  exp_data;
  } table_row_t;

  logic        clock;
  logic        rst_n;
  logic        flush;
  fifo_data_t  write_data;
  logic        write_valid;
  logic        write_ready;
  fifo_data_t  read_data;
  logic        read_valid;
  logic        read_ready;
  fifo_flags_t flags;
  fifo_count_t level;
  fifo_count_t space;
  fifo_count_t lower_threshold_level;
  logic        lower_threshold_status;
  fifo_count_t upper_threshold_level;
  logic        upper_threshold_status;

  table_row_t  table_rows[$];
  string       row_names[$];
  int          cycle_limit = 0;

  `include "fifo_tb_checks.svh"

  valid_ready_advanced_fifo dut (
    .clock                  ( clock                  ),
    .rst_n                  ( rst_n                  ),
    .flush                  ( flush                  ),
    .write_data             ( write_data             ),
    .write_valid            ( write_valid            ),
    .write_ready            ( write_ready            ),
    .read_data              ( read_data              ),
    .read_valid             ( read_valid             ),
    .read_ready             ( read_ready             ),
    .flags                  ( flags                  ),
    .level                  ( level                  ),
    .space                  ( space                  ),
    .lower_threshold_level  ( lower_threshold_level  ),
    .lower_threshold_status ( lower_threshold_status ),
    .upper_threshold_level  ( upper_threshold_level  ),
    .upper_threshold_status ( upper_threshold_status )
  );

  // 4 ns clock
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic add_row(input string name, input logic fl, input logic wv,
                         input fifo_data_t wd, input logic rr, input fifo_count_t lo,
                         input fifo_count_t hi, input fifo_count_t cnt,
                         input fifo_flags_t fg, input fifo_data_t data);
    table_row_t row;
    row = '{fl, wv, wd, rr, lo, hi, cnt, fg, data};
    table_rows.push_back(row);
    row_names.push_back(name);
  endtask

  task automatic build_table();
    add_row("idle_after_reset", 0, 0, 8'h00, 0, 2, 6, 0, FLAGS_0, 8'h00);
    // Fill to full with thresholds at 2 and 6
    add_row("fill_1",           0, 1, 8'h11, 0, 2, 6, 1, FLAGS_1, 8'h11);
    add_row("fill_2",           0, 1, 8'h22, 0, 2, 6, 2, FLAGS_2, 8'h11);
    add_row("fill_3",           0, 1, 8'h33, 0, 2, 6, 3, FLAGS_3, 8'h11);
    add_row("fill_4",           0, 1, 8'h44, 0, 2, 6, 4, FLAGS_4, 8'h11);
    add_row("fill_5",           0, 1, 8'h55, 0, 2, 6, 5, FLAGS_5, 8'h11);
    add_row("fill_6",           0, 1, 8'h66, 0, 2, 6, 6, FLAGS_6, 8'h11);
    add_row("fill_7",           0, 1, 8'h77, 0, 2, 6, 7, FLAGS_7, 8'h11);
    add_row("fill_8",           0, 1, 8'h88, 0, 2, 6, 8, FLAGS_8, 8'h11);
    add_row("fill_refused",     0, 1, 8'h99, 0, 2, 6, 8, FLAGS_8, 8'h11);
    // Order and back-pressure
    add_row("hold_head",        0, 0, 8'h00, 0, 2, 6, 8, FLAGS_8, 8'h11);
    add_row("read_1",           0, 0, 8'h00, 1, 2, 6, 7, FLAGS_7, 8'h22);
    add_row("hold_again",       0, 0, 8'h00, 0, 2, 6, 7, FLAGS_7, 8'h22);
    add_row("read_2",           0, 0, 8'h00, 1, 2, 6, 6, FLAGS_6, 8'h33);
    add_row("read_3",           0, 0, 8'h00, 1, 2, 6, 5, FLAGS_5, 8'h44);
    // Push and pop in the same cycle
    add_row("read_write_1",     0, 1, 8'ha1, 1, 2, 6, 5, FLAGS_5, 8'h55);
    add_row("read_write_2",     0, 1, 8'hb2, 1, 2, 6, 5, FLAGS_5, 8'h66);
    add_row("drain_1",          0, 0, 8'h00, 1, 2, 6, 4, FLAGS_4, 8'h77);
    // Thresholds moved to 0 and 8
    add_row("thresh_wide",      0, 0, 8'h00, 0, 0, 8, 4, FLAGS_4, 8'h77);
    add_row("drain_2",          0, 0, 8'h00, 1, 0, 8, 3, FLAGS_3, 8'h88);
    add_row("drain_3",          0, 0, 8'h00, 1, 0, 8, 2, FLAGS_2, 8'ha1);
    add_row("drain_4",          0, 0, 8'h00, 1, 0, 8, 1, FLAGS_1, 8'hb2);
    add_row("drain_5",          0, 0, 8'h00, 1, 0, 8, 0, FLAGS_0, 8'h00);
    add_row("refill_1",         0, 1, 8'hc1, 0, 0, 8, 1, FLAGS_1, 8'hc1);
    add_row("refill_2",         0, 1, 8'hc2, 0, 0, 8, 2, FLAGS_2, 8'hc1);
    add_row("refill_3",         0, 1, 8'hc3, 0, 0, 8, 3, FLAGS_3, 8'hc1);
    add_row("refill_4",         0, 1, 8'hc4, 0, 0, 8, 4, FLAGS_4, 8'hc1);
    add_row("refill_5",         0, 1, 8'hc5, 0, 0, 8, 5, FLAGS_5, 8'hc1);
    add_row("refill_6",         0, 1, 8'hc6, 0, 0, 8, 6, FLAGS_6, 8'hc1);
    add_row("refill_7",         0, 1, 8'hc7, 0, 0, 8, 7, FLAGS_7, 8'hc1);
    add_row("refill_8",         0, 1, 8'hc8, 0, 0, 8, 8, FLAGS_8, 8'hc1);
    // Flush drops the queue and the word written with it
    add_row("drain_before_flush", 0, 0, 8'h00, 1, 0, 8, 7, FLAGS_7, 8'hc2);
    add_row("flush_with_write",   1, 1, 8'hee, 0, 0, 8, 0, FLAGS_0, 8'h00);
    add_row("idle_after_flush",   0, 0, 8'h00, 0, 0, 8, 0, FLAGS_0, 8'h00);
    add_row("write_after_flush",  0, 1, 8'h5a, 0, 0, 8, 1, FLAGS_1, 8'h5a);
  endtask

  task automatic drive_inputs(input logic fl, input logic wv, input fifo_data_t wd,
                              input logic rr, input fifo_count_t lo, input fifo_count_t hi);
    flush                 = fl;
    write_valid           = wv;
    write_data            = wd;
    read_ready            = rr;
    lower_threshold_level = lo;
    upper_threshold_level = hi;
  endtask

  // Full output check against one expected state
  task automatic check_outputs(input string name, input fifo_count_t exp_count,
                               input fifo_flags_t exp_flags, input fifo_data_t exp_data,
                               input fifo_count_t lo, input fifo_count_t hi);
    fifo_count_t exp_space;
    exp_space = fifo_count_t'(`FIFO_DEPTH) - exp_count;
    check_count(name, "level", exp_count, level);
    check_count(name, "space", exp_space, space);
    check_flags(name, exp_flags, flags);
    check_status(name, "write_ready", exp_flags.not_full, write_ready);
    check_status(name, "read_valid", exp_flags.not_empty, read_valid);
    check_status(name, "lower_threshold_status", exp_count <= lo, lower_threshold_status);
    check_status(name, "upper_threshold_status", exp_count >= hi, upper_threshold_status);
    // Data only meaningful with something queued
    if (exp_flags.not_empty) begin
      check_data(name, exp_data, read_data);
    end
  endtask

  // Cycle budget set once the table is known
  initial begin : watchdog
    int cycles;
    cycles = 0;
    wait (cycle_limit != 0);
    while (cycles < cycle_limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    abort_run();
  end

  initial begin : run
    table_row_t  row;
    logic        rand_flush;
    logic        rand_write;
    logic        rand_read;
    fifo_data_t  rand_data;
    fifo_count_t rand_lo;
    fifo_count_t rand_hi;
    logic        push_ok;
    logic        pop_ok;
    void'($urandom(RANDOM_SEED));
    rst_n = 1'b0;
    drive_inputs(0, 0, 8'h00, 0, 2, 6);
    build_table();
    cycle_limit = table_rows.size() + RANDOM_CYCLES + 100;
    // Reset held low for 3 cycles then released after an edge
    repeat (3) @(posedge clock);
    #1 rst_n = 1'b1;
    check_outputs("reset_state", 0, FLAGS_0, 8'h00, 2, 6);
    // Directed table with one row per cycle
    for (int i = 0; i < table_rows.size(); i++) begin
      row = table_rows[i];
      drive_inputs(row.flush, row.write_valid, row.write_data, row.read_ready,
                   row.lower_level, row.upper_level);
      @(posedge clock);
      #1;
      check_outputs(row_names[i], row.exp_count, row.exp_flags, row.exp_data,
                    row.lower_level, row.upper_level);
    end
    // Model starts from the state the table left
    model_q.delete();
    model_q.push_back(8'h5a);
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      rand_flush = ($urandom() % 32) == 0;
      rand_write = 1'($urandom() % 2);
      rand_read  = 1'($urandom() % 2);
      rand_data  = fifo_data_t'($urandom());
      rand_lo    = fifo_count_t'($urandom() % (`FIFO_DEPTH + 1));
      rand_hi    = fifo_count_t'($urandom() % (`FIFO_DEPTH + 1));
      drive_inputs(rand_flush, rand_write, rand_data, rand_read, rand_lo, rand_hi);
      // Acceptance from the occupancy before the edge
      push_ok = rand_write && (model_q.size() < `FIFO_DEPTH);
      pop_ok  = rand_read && (model_q.size() > 0);
      @(posedge clock);
      #1;
      model_step(rand_flush, push_ok, rand_data, pop_ok);
      check_outputs($sformatf("random_%0d", n), fifo_count_t'(model_q.size()),
                    expected_flags(model_q.size()),
                    (model_q.size() > 0) ? model_q[0] : 8'h00, rand_lo, rand_hi);
    end
    drive_inputs(0, 0, 8'h00, 0, 2, 6);
    $display("TEST OK");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
+incdir+test
design/fifo_pkg.sv
design/simple_dual_port_ram.sv
design/fifo_status_flags.sv
design/advanced_fifo_controller.sv
design/valid_ready_advanced_fifo.sv
test/fifo_tb.sv
